// ==== tb.f ====
common/codec_init_pkg.sv
init_sequencer/init_rom.sv
init_sequencer/init_sequencer.sv
i2c_master/i2c_bit_engine.sv
i2c_master/i2c_byte_ctrl.sv
verilog/codec_init_top.sv
verif/i2c_target_model.sv
verif/tb_codec_init.sv

// ==== Bender.yml ====
package:
  name: codec_init

sources:
  - common/codec_init_pkg.sv
  - init_sequencer/init_rom.sv
  - init_sequencer/init_sequencer.sv
  - i2c_master/i2c_bit_engine.sv
  - i2c_master/i2c_byte_ctrl.sv
  - verilog/codec_init_top.sv
  - target: test
    files:
      - verif/i2c_target_model.sv
      - verif/tb_codec_init.sv

// ==== verif/tb_codec_init.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_codec_init;
    localparam int         CLK_FREQ      = 50_000_000;
    localparam int         I2C_FREQ      = CLK_FREQ / 16;
    localparam logic [6:0] DEV_ADDR      = 7'h1a;
    localparam int         UNIT_CYCLES   = 64;
    localparam int         CLK_NS        = 20;
    localparam int         N_WRITES      = 7;
    localparam int         BIT_CYCLES    = CLK_FREQ / I2C_FREQ;    // one scl period
    localparam int         OPS_PER_WRITE = 29;                     // start, 3 x 9 bits, stop
    localparam int         SETTLE_CYCLES = 4 * UNIT_CYCLES;
    localparam int         IDLE_CYCLES   = 40 * BIT_CYCLES;
    localparam int         RUN_CYCLES    = (N_WRITES + 2) * OPS_PER_WRITE * (BIT_CYCLES + 2)
                                           + SETTLE_CYCLES + 100;
    localparam int         LIMIT_CYCLES  = 2 * (3 * RUN_CYCLES + 2 * IDLE_CYCLES);

    logic clk;
    logic reset;
    logic clear;
    int   refuse_idx;
    wire  scl;
    wire  sda;
    wire  mute_n;
    wire  init_done;

    logic [6:0] exp_addr [N_WRITES];
    logic [8:0] exp_data [N_WRITES];
    int         errors;
    int         tests;
    int         failed_tests;
    time        mute_rise;

    pullup (scl);
    pullup (sda);

    codec_init_top #(
        .CLK_FREQ          (CLK_FREQ),
        .I2C_FREQ          (I2C_FREQ),
        .DEV_ADDR          (DEV_ADDR),
        .DELAY_UNIT_CYCLES (UNIT_CYCLES)
    ) codec_init_top_i (
        .clk       (clk),
        .reset     (reset),
        .scl       (scl),
        .sda       (sda),
        .mute_n    (mute_n),
        .init_done (init_done)
    );

    i2c_target_model #(
        .DEV_ADDR (DEV_ADDR)
    ) target_i (
        .scl        (scl),
        .sda        (sda),
        .clear      (clear),
        .refuse_idx (refuse_idx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_NS);
        $display("timeout, run did not finish within %0d cycles", LIMIT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // first time mute_n is seen high since the last reset
    always @(negedge clk) begin
        if (reset) begin
            mute_rise <= 0;
        end else if (mute_n === 1'b1 && mute_rise == 0) begin
            mute_rise <= $time;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors != err0) begin
            failed_tests++;
        end
        $display("test %-14s %s, %0d errors", name, errors == err0 ? "ok" : "failed",
                 errors - err0);
    endtask

    task automatic apply_reset(input int refuse);
        @(posedge clk);
        reset      <= 1'b1;
        refuse_idx <= refuse;
        repeat (7) @(posedge clk);
        clear <= 1'b1;          // log restarts with the table
        @(posedge clk);
        reset <= 1'b0;
        clear <= 1'b0;
    endtask

    task automatic wait_init_done();
        int n;
        n = 0;
        while (init_done !== 1'b1 && n < RUN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (init_done !== 1'b1) begin
            $display("init_done did not rise within %0d cycles", RUN_CYCLES);
            errors++;
        end
    endtask

    task automatic wait_starts(input int target);
        int n;
        n = 0;
        while (target_i.starts < target && n < RUN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (target_i.starts < target) begin
            $display("start condition %0d never appeared on the bus", target);
            errors++;
        end
    endtask

    task automatic check_addresses();
        for (int i = 0; i < target_i.count && i < 64; i++) begin
            check_value($sformatf("dev byte[%0d]", i), target_i.log_dev[i], {DEV_ADDR, 1'b0});
        end
    endtask

    // skip is the record of a refused transfer, -1 if there is none
    task automatic check_sequence(input int skip);
        int rec;
        check_value("transfer count", target_i.count, N_WRITES + (skip >= 0 ? 1 : 0));
        for (int i = 0; i < N_WRITES; i++) begin
            rec = (skip >= 0 && i >= skip) ? i + 1 : i;
            check_value($sformatf("byte count[%0d]", rec), target_i.log_nbytes[rec], 3);
            check_value($sformatf("reg_addr[%0d]", rec), target_i.log_b1[rec][7:1], exp_addr[i]);
            check_value($sformatf("reg_data[%0d]", rec),
                        {target_i.log_b1[rec][0], target_i.log_b2[rec]}, exp_data[i]);
        end
    endtask

    task automatic check_mute_and_idle();
        int bad;
        int n0;
        bad = 0;
        n0  = target_i.count;
        @(negedge clk);
        check_value("mute_n", mute_n, 1);
        check_value("init_done", init_done, 1);
        check_value("mute_n rise after last stop",
                    mute_rise > target_i.log_stop_t[n0 - 1], 1);
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            if (scl !== 1'b1 || sda !== 1'b1 || mute_n !== 1'b1 || init_done !== 1'b1) begin
                bad++;
            end
        end
        check_value("samples with busy bus", bad, 0);
        check_value("transfer count after done", target_i.count, n0);
    endtask

    initial begin
        int  err0;
        time gap;
        exp_addr[0] = 7'h06;
        exp_data[0] = 9'h077;
        exp_addr[1] = 7'h04;
        exp_data[1] = 9'h012;
        exp_addr[2] = 7'h05;
        exp_data[2] = 9'h000;
        exp_addr[3] = 7'h07;
        exp_data[3] = 9'h002;
        exp_addr[4] = 7'h08;
        exp_data[4] = 9'h000;
        exp_addr[5] = 7'h09;
        exp_data[5] = 9'h001;
        exp_addr[6] = 7'h06;
        exp_data[6] = 9'h067;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        reset        = 1'b1;
        clear        = 1'b0;
        refuse_idx   = -1;

        // full run, address byte of the third transfer refused once
        apply_reset(2);
        err0 = errors;
        check_value("mute_n after reset", mute_n, 0);
        check_value("init_done after reset", init_done, 0);
        wait_init_done();
        check_addresses();
        finish_test("address", err0);
        err0 = errors;
        check_sequence(2);
        finish_test("sequence", err0);
        err0 = errors;
        check_value("refused byte count", target_i.log_nbytes[2], 1);
        check_value("refused dev byte", target_i.log_dev[2], {DEV_ADDR, 1'b0});
        finish_test("nack_retry", err0);
        err0 = errors;
        check_mute_and_idle();
        finish_test("mute_release", err0);

        // reset inside the address byte of write four
        apply_reset(-1);
        err0 = errors;
        wait_starts(4);
        repeat (3 * BIT_CYCLES) @(posedge clk);
        apply_reset(-1);
        @(negedge clk);
        check_value("mute_n after mid reset", mute_n, 0);
        check_value("init_done after mid reset", init_done, 0);
        wait_init_done();
        check_sequence(-1);
        check_mute_and_idle();
        finish_test("reset_midseq", err0);
        err0 = errors;
        gap  = target_i.log_start_t[5] - target_i.log_stop_t[4];
        check_value("settle gap long enough", gap >= SETTLE_CYCLES * CLK_NS, 1);
        finish_test("settle_delay", err0);

        $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/i2c_target_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] DEV_ADDR = 7'h1a,
    parameter int         MAX_LOG  = 64
)(
    inout wire  scl,
    inout wire  sda,
    input logic clear,          // drop the log and any transfer in flight
    input int   refuse_idx      // transfer whose address byte gets no ack, -1 none
);
    logic [7:0] log_dev     [MAX_LOG];
    logic [7:0] log_b1      [MAX_LOG];
    logic [7:0] log_b2      [MAX_LOG];
    int         log_nbytes  [MAX_LOG];
    time        log_start_t [MAX_LOG];
    time        log_stop_t  [MAX_LOG];
    int         count  = 0;     // finished transfers
    int         starts = 0;     // start conditions seen

    logic       active    = 1'b0;
    logic       addr_ok   = 1'b0;
    logic       sda_drive = 1'b0;
    logic [7:0] shifter   = '0;
    int         bit_n     = 0;
    int         byte_n    = 0;
    time        start_t   = 0;

    assign sda = sda_drive ? 1'b0 : 1'bz;

    always @(negedge sda) begin
        if (scl === 1'b1) begin     // start or repeated start
            active  = 1'b1;
            bit_n   = 0;
            byte_n  = 0;
            start_t = $time;
            starts++;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && active) begin   // stop, close the record
            if (count < MAX_LOG) begin
                log_nbytes[count]  = byte_n;
                log_start_t[count] = start_t;
                log_stop_t[count]  = $time;
            end
            count++;
            active = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active && bit_n < 8) begin
            shifter = {shifter[6:0], sda};  // msb first
            bit_n++;
        end
    end

    always @(negedge scl) begin
        if (active && bit_n == 8) begin
            if (count < MAX_LOG) begin
                case (byte_n)
                    0:       log_dev[count] = shifter;
                    1:       log_b1[count]  = shifter;
                    default: log_b2[count]  = shifter;
                endcase
            end
            if (byte_n == 0) begin
                addr_ok = shifter == {DEV_ADDR, 1'b0} && count != refuse_idx;
            end
            byte_n++;
            bit_n     = 9;
            sda_drive = addr_ok;    // ack slot
        end else if (active && bit_n == 9) begin
            bit_n     = 0;
            sda_drive = 1'b0;
        end
    end

    always @(posedge clear) begin
        count     = 0;
        starts    = 0;
        active    = 1'b0;
        bit_n     = 0;
        byte_n    = 0;
        sda_drive = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/codec_init_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module codec_init_top #(
    parameter int         CLK_FREQ          = 50_000_000,
    parameter int         I2C_FREQ          = 100_000,
    parameter logic [6:0] DEV_ADDR          = 7'h1a,
    parameter int         DELAY_UNIT_CYCLES = 1_000_000     // 20 ms at 50 MHz
)(
    input  wire clk,
    input  wire reset,
    inout  wire scl,
    inout  wire sda,
    output wire mute_n,
    output wire init_done
);
    wire       byte_cmd;
    wire [7:0] byte_data;
    wire       byte_start;
    wire       byte_stop;
    wire       byte_done;
    wire       byte_ack;
    wire       bit_cmd;
    wire [1:0] bit_op;
    wire       bit_wdata;
    wire       bit_done;
    wire       bit_rdata;
    wire       scl_oe;
    wire       sda_oe;

    init_sequencer #(
        .DEV_ADDR          (DEV_ADDR),
        .DELAY_UNIT_CYCLES (DELAY_UNIT_CYCLES)
    ) init_sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .byte_cmd   (byte_cmd),
        .byte_data  (byte_data),
        .byte_start (byte_start),
        .byte_stop  (byte_stop),
        .byte_done  (byte_done),
        .byte_ack   (byte_ack),
        .mute_n     (mute_n),
        .init_done  (init_done)
    );

    i2c_byte_ctrl i2c_byte_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .byte_cmd   (byte_cmd),
        .byte_data  (byte_data),
        .byte_start (byte_start),
        .byte_stop  (byte_stop),
        .byte_done  (byte_done),
        .byte_ack   (byte_ack),
        .bit_cmd    (bit_cmd),
        .bit_op     (bit_op),
        .bit_wdata  (bit_wdata),
        .bit_done   (bit_done),
        .bit_rdata  (bit_rdata)
    );

    i2c_bit_engine #(
        .CLK_FREQ (CLK_FREQ),
        .I2C_FREQ (I2C_FREQ)
    ) i2c_bit_engine_i (
        .clk       (clk),
        .reset     (reset),
        .bit_cmd   (bit_cmd),
        .bit_op    (bit_op),
        .bit_wdata (bit_wdata),
        .bit_done  (bit_done),
        .bit_rdata (bit_rdata),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    // open drain, pull-ups are off chip
    assign scl = scl_oe ? 1'b0 : 1'bz;
    assign sda = sda_oe ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

// ==== i2c_master/i2c_byte_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_ctrl import codec_init_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_cmd,
    input  logic [7:0] byte_data,
    input  logic       byte_start,
    input  logic       byte_stop,
    output logic       byte_done,
    output logic       byte_ack,
    output logic       bit_cmd,
    output logic [1:0] bit_op,
    output logic       bit_wdata,
    input  logic       bit_done,
    input  logic       bit_rdata
);
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_START = 3'd1;
    localparam logic [2:0] ST_SHIFT = 3'd2;
    localparam logic [2:0] ST_ACK   = 3'd3;
    localparam logic [2:0] ST_STOP  = 3'd4;

    logic [2:0] state;
    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    logic       stop_req;

    assign bit_wdata = shreg[7];    // msb first

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            bit_cmd   <= 1'b0;
            bit_op    <= BIT_OP_STOP;
            byte_done <= 1'b0;
            byte_ack  <= 1'b0;
            bit_cnt   <= '0;
            stop_req  <= 1'b0;
        end else begin
            bit_cmd   <= 1'b0;
            byte_done <= 1'b0;
            case (state)
                ST_IDLE: if (byte_cmd) begin
                    shreg    <= byte_data;
                    stop_req <= byte_stop;
                    bit_cnt  <= '0;
                    bit_cmd  <= 1'b1;
                    if (byte_start) begin
                        bit_op <= BIT_OP_START;
                        state  <= ST_START;
                    end else begin
                        bit_op <= BIT_OP_WRITE;
                        state  <= ST_SHIFT;
                    end
                end
                ST_START: if (bit_done) begin
                    bit_cmd <= 1'b1;
                    bit_op  <= BIT_OP_WRITE;
                    state   <= ST_SHIFT;
                end
                ST_SHIFT: if (bit_done) begin
                    bit_cmd <= 1'b1;
                    if (bit_cnt == 3'd7) begin
                        bit_op <= BIT_OP_READ;  // ack slot, sda released
                        state  <= ST_ACK;
                    end else begin
                        shreg   <= {shreg[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 3'd1;
                        bit_op  <= BIT_OP_WRITE;
                    end
                end
                ST_ACK: if (bit_done) begin
                    byte_ack <= ~bit_rdata;
                    // a nack always closes the transfer
                    if (stop_req || bit_rdata) begin
                        bit_cmd <= 1'b1;
                        bit_op  <= BIT_OP_STOP;
                        state   <= ST_STOP;
                    end else begin
                        byte_done <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                ST_STOP: if (bit_done) begin
                    byte_done <= 1'b1;
                    state     <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== i2c_master/i2c_bit_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine import codec_init_pkg::*; #(
    parameter int CLK_FREQ = 50_000_000,
    parameter int I2C_FREQ = 100_000
)(
    input  logic       clk,
    input  logic       reset,
    input  logic       bit_cmd,
    input  logic [1:0] bit_op,
    input  logic       bit_wdata,
    output logic       bit_done,
    output logic       bit_rdata,
    output logic       scl_oe,
    output logic       sda_oe,
    input  logic       sda_in
);
    localparam int PRESCALE = CLK_FREQ / (4 * I2C_FREQ) - 1;   // quarter bit
    localparam int PRESC_W  = $clog2(PRESCALE + 2);

    logic               busy;
    logic [1:0]         phase;
    logic [PRESC_W-1:0] presc_cnt;
    logic [1:0]         op;
    logic               wdata;
    logic               scl_lvl;
    logic               sda_lvl;
    logic               sda_sync;
    logic               phase_end;

    // line levels for one phase of an operation, {scl, sda}
    function automatic logic [1:0] phase_levels(input logic [1:0] op_f, input logic [1:0] ph,
                                                input logic wd, input logic scl_now);
        logic [1:0] lv;
        case (op_f)
            BIT_OP_START: begin
                case (ph)
                    2'd0:    lv = {scl_now, 1'b1};  // sda up first, repeated start safe
                    2'd1:    lv = 2'b11;
                    2'd2:    lv = 2'b10;            // sda falls while scl high
                    default: lv = 2'b00;
                endcase
            end
            BIT_OP_STOP: begin
                case (ph)
                    2'd0:    lv = 2'b00;
                    2'd1:    lv = 2'b10;
                    default: lv = 2'b11;            // sda rises while scl high
                endcase
            end
            BIT_OP_WRITE: lv = {ph == 2'd1 || ph == 2'd2, wd};
            default:      lv = {ph == 2'd1 || ph == 2'd2, 1'b1};
        endcase
        return lv;
    endfunction

    assign phase_end = presc_cnt == PRESC_W'(PRESCALE);
    assign bit_done  = busy && phase == 2'd3 && phase_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            phase     <= '0;
            presc_cnt <= '0;
            scl_lvl   <= 1'b1;  // bus released
            sda_lvl   <= 1'b1;
        end else if (bit_cmd) begin
            busy      <= 1'b1;
            phase     <= '0;
            presc_cnt <= '0;
            {scl_lvl, sda_lvl} <= phase_levels(bit_op, 2'd0, bit_wdata, scl_lvl);
        end else if (busy) begin
            if (!phase_end) begin
                presc_cnt <= presc_cnt + 1'b1;
            end else begin
                presc_cnt <= '0;
                if (phase == 2'd3) begin
                    busy <= 1'b0;   // levels held until next op
                end else begin
                    phase <= phase + 2'd1;
                    {scl_lvl, sda_lvl} <= phase_levels(op, phase + 2'd1, wdata, scl_lvl);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        sda_sync <= sda_in;
        if (bit_cmd) begin
            op    <= bit_op;
            wdata <= bit_wdata;
        end
        // sample at the end of the second scl high phase
        if (busy && op == BIT_OP_READ && phase == 2'd2 && phase_end) begin
            bit_rdata <= sda_sync;
        end
    end

    assign scl_oe = ~scl_lvl;
    assign sda_oe = ~sda_lvl;

endmodule

`default_nettype wire

// ==== init_sequencer/init_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module init_sequencer import codec_init_pkg::*; #(
    parameter logic [6:0] DEV_ADDR          = 7'h1a,
    parameter int         DELAY_UNIT_CYCLES = 1_000_000
)(
    input  logic       clk,
    input  logic       reset,
    output logic       byte_cmd,
    output logic [7:0] byte_data,
    output logic       byte_start,
    output logic       byte_stop,
    input  logic       byte_done,
    input  logic       byte_ack,
    output logic       mute_n,
    output logic       init_done
);
    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_WAIT  = 2'd1;
    localparam logic [1:0] S_DELAY = 2'd2;
    localparam logic [1:0] S_DONE  = 2'd3;

    logic [1:0]  state;
    entry_idx_t  idx;
    logic [1:0]  byte_cnt;      // 0 dev addr, 1 reg addr, 2 data
    logic [31:0] delay_cnt;
    init_entry_t entry;
    reg_write_t  wr;
    logic [31:0] delay_len;
    logic        last_entry;

    init_rom init_rom_i (
        .idx   (idx),
        .entry (entry)
    );

    assign wr         = entry.payload.wr;
    assign delay_len  = 32'(entry.payload.dly.units) * 32'(DELAY_UNIT_CYCLES);
    assign last_entry = idx == entry_idx_t'(INIT_LEN - 1);

    always_comb begin
        case (byte_cnt)
            2'd0:    byte_data = {DEV_ADDR, 1'b0};              // write bit low
            2'd1:    byte_data = {wr.reg_addr, wr.reg_data[8]};
            default: byte_data = wr.reg_data[7:0];
        endcase
    end

    assign byte_start = byte_cnt == 2'd0;
    assign byte_stop  = byte_cnt == 2'd2;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_FETCH;
            idx       <= '0;
            byte_cnt  <= '0;
            delay_cnt <= '0;
            byte_cmd  <= 1'b0;
        end else begin
            byte_cmd <= 1'b0;
            case (state)
                S_FETCH: begin
                    byte_cnt <= '0;
                    if (entry.kind == ENTRY_DELAY) begin
                        delay_cnt <= delay_len;
                        state     <= S_DELAY;
                    end else begin
                        byte_cmd <= 1'b1;   // device address byte
                        state    <= S_WAIT;
                    end
                end
                S_WAIT: if (byte_done) begin
                    if (!byte_ack) begin
                        byte_cnt <= '0;     // nack, restart from start condition
                        byte_cmd <= 1'b1;
                    end else if (byte_cnt != 2'd2) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        byte_cmd <= 1'b1;
                    end else if (last_entry) begin
                        state <= S_DONE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= S_FETCH;
                    end
                end
                S_DELAY: begin
                    if (delay_cnt > 32'd1) begin
                        delay_cnt <= delay_cnt - 32'd1;
                    end else if (last_entry) begin
                        state <= S_DONE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= S_FETCH;
                    end
                end
                default: state <= S_DONE;   // table done, stay here
            endcase
        end
    end

    assign init_done = state == S_DONE;
    assign mute_n    = state == S_DONE;   // unmute only after the last write

endmodule

`default_nettype wire

// ==== init_sequencer/init_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module init_rom import codec_init_pkg::*; (
    input  entry_idx_t  idx,
    output init_entry_t entry
);
    function automatic init_entry_t wr_entry(input logic [6:0] addr, input logic [8:0] data);
        init_entry_t e;
        e.kind = ENTRY_WRITE;
        e.payload.wr.reg_addr = addr;
        e.payload.wr.reg_data = data;
        return e;
    endfunction

    function automatic init_entry_t dly_entry(input logic [15:0] units);
        init_entry_t e;
        e.kind = ENTRY_DELAY;
        e.payload.dly.units = units;
        return e;
    endfunction

    always_comb begin
        case (idx)
            3'd0:    entry = wr_entry(7'h06, 9'h077);   // power up all but the output stage
            3'd1:    entry = wr_entry(7'h04, 9'h012);   // dac select, bypass off
            3'd2:    entry = wr_entry(7'h05, 9'h000);   // dac soft mute off
            3'd3:    entry = wr_entry(7'h07, 9'h002);   // i2s, 16 bit
            3'd4:    entry = wr_entry(7'h08, 9'h000);   // normal mode, 48 kHz
            3'd5:    entry = dly_entry(16'd4);          // let coupling caps charge
            3'd6:    entry = wr_entry(7'h09, 9'h001);   // core active
            default: entry = wr_entry(7'h06, 9'h067);   // output stage on
        endcase
    end

endmodule

`default_nettype wire

// ==== common/codec_init_pkg.sv ====
`default_nettype none

package codec_init_pkg;

    // table entry kind
    typedef enum logic {
        ENTRY_WRITE = 1'b0,
        ENTRY_DELAY = 1'b1
    } entry_kind_t;

    // register write, 7-bit address and 9-bit data
    typedef struct packed {
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } reg_write_t;

    typedef struct packed {
        logic [15:0] units;     // length in delay units
    } settle_delay_t;

    // same 16-bit word, read according to the entry kind
    typedef union packed {
        reg_write_t    wr;
        settle_delay_t dly;
    } entry_payload_u;

    typedef struct packed {
        entry_kind_t    kind;
        entry_payload_u payload;
    } init_entry_t;

    localparam int INIT_LEN = 8;    // seven writes and one delay

    typedef logic [$clog2(INIT_LEN)-1:0] entry_idx_t;

    // bit engine operations
    localparam logic [1:0] BIT_OP_START = 2'd0;
    localparam logic [1:0] BIT_OP_STOP  = 2'd1;
    localparam logic [1:0] BIT_OP_WRITE = 2'd2;
    localparam logic [1:0] BIT_OP_READ  = 2'd3;

endpackage

`default_nettype wire
